// ==== rv_core.f ====
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_fetch.sv
design/rv_hazard.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_writeback.sv
design/rv_core.sv
verification/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - design
    files:
      - design/rv_isa_pkg.sv
      - design/rv_pipe_pkg.sv
      - design/rv_fetch.sv
      - design/rv_hazard.sv
      - design/rv_regfile.sv
      - design/rv_decode.sv
      - design/rv_execute.sv
      - design/rv_writeback.sv
      - design/rv_core.sv
      - target: simulation
        files:
          - verification/rv_core_tb.sv

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_core_tb
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    localparam time         CLK_PERIOD = 40ns;
    localparam int          RST_CYCLES = 5;
    localparam int          N_INDEP    = 48;        // After the 31 seed writes
    localparam int          N_DEP      = 32;
    localparam int          PROG_MAX   = 128;
    localparam int          DRAIN      = 12;        // Idle cycles to catch stray commits
    localparam logic [31:0] NOP_WORD   = 32'h0000_0013;   // ADDI x0, x0, 0

    localparam int T_RESET = 0;
    localparam int T_INDEP = 1;
    localparam int T_DEP   = 2;
    localparam int T_X0    = 3;
    localparam int T_FETCH = 4;

    // Expected register write and the test it belongs to
    typedef struct packed {
        logic [2:0]            test;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } exp_t;

    logic                clk;
    logic                rst_n;
    logic [`RV_XLEN-1:0] imem_addr;
    logic [`RV_XLEN-1:0] imem_insn;
    rv_commit_t          commit;

    logic [31:0] prog [PROG_MAX];
    int          prog_len = 0;
    bit          prog_built = 1'b0;
    logic [31:0] arch [`RV_NUM_REGS];       // Architectural register model
    logic [4:0]  last_rd [2];               // Newest destination in slot 0
    logic [15:0] lfsr = 16'd3;
    exp_t        exp_q [$];                 // Writes in program order
    exp_t        head;
    int          pending [5];
    int          errors [5];
    string       test_names [5] = '{"reset", "independent", "dependent", "x0_noop", "fetch"};
    int          checks_run = 0;
    int          commits_seen = 0;
    int          total_expected = 0;
    logic [31:0] prev_addr = `RV_RESET_PC;

    rv_core u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_insn (imem_insn),
        .commit    (commit)
    );

    // Instruction memory answers in the same cycle
    assign imem_insn = (imem_addr[31:2] < prog_len) ? prog[imem_addr[31:2]] : NOP_WORD;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Random source and program generation
    ////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};     // One step per bit
        end
    endtask

    // Random index that misses both avoided registers unless it is x0
    task automatic pick_reg(input logic [4:0] avoid_a, input logic [4:0] avoid_b,
                            input bit nonzero, output logic [4:0] r);
        logic [31:0] v;
        do begin
            take_bits(5, v);
            r = v[4:0];
        end while ((nonzero && r == 5'd0) || (r != 5'd0 && (r == avoid_a || r == avoid_b)));
    endtask

    // Op index 0-7 I group by funct3, 8 SRAI, 9-16 R group by funct3, 17 SUB, 18 SRA
    task automatic make_op(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, output logic [31:0] insn);
        logic [31:0] v;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        take_bits(12, v);
        imm = v[11:0];
        alt = (op == 8) || (op >= 17);            // insn[30]
        if (op < 9) begin
            f3 = (op == 8) ? 3'd5 : 3'(op);
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm[11:5] = {1'b0, alt, 5'b00000};   // Shift funct7 in imm
            end
            insn = {imm, rs1, f3, rd, OPC_OP_IMM};
        end else begin
            f3   = (op == 17) ? 3'd0 : (op == 18) ? 3'd5 : 3'(op - 9);
            insn = {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, OPC_OP};
        end
    endtask

    // Expected result straight from the ISA rules
    function automatic logic [31:0] rv_ref_exec(input logic [31:0] insn,
                                                input logic [31:0] a,
                                                input logic [31:0] rs2_val);
        logic        is_reg;
        logic [31:0] b;
        logic [4:0]  sh;
        is_reg = (insn[6:0] == OPC_OP);
        b      = is_reg ? rs2_val : {{20{insn[31]}}, insn[31:20]};
        sh     = b[4:0];
        case (insn[14:12])
            3'd0:    return (is_reg && insn[30]) ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};          // Unsigned
            3'd4:    return a ^ b;
            3'd5:    return insn[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Append to program, run the model, queue any visible write
    task automatic add_insn(input logic [31:0] insn, input int test);
        rv_insn_r_t  f;
        exp_t        e;
        f              = insn;
        prog[prog_len] = insn;
        prog_len++;
        if (f.opcode == OPC_OP || f.opcode == OPC_OP_IMM) begin
            last_rd[1] = last_rd[0];
            last_rd[0] = f.rd;
            if (f.rd != 5'd0) begin
                e.test   = 3'(test);
                e.rd     = f.rd;
                e.data   = rv_ref_exec(insn, arch[f.rs1], arch[f.rs2]);
                arch[f.rd] = e.data;     // arch[0] is never written
                exp_q.push_back(e);
                pending[test]++;
                total_expected++;
            end
        end
    endtask

    task automatic build_program();
        logic [31:0] v;
        logic [31:0] insn;
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        foreach (arch[r]) arch[r] = '0;
        last_rd[0] = 5'd0;
        last_rd[1] = 5'd0;
        for (int r = 1; r < `RV_NUM_REGS; r++) begin
            take_bits(12, v);
            add_insn({v[11:0], 5'd0, 3'd0, 5'(r), OPC_OP_IMM}, T_INDEP);   // ADDI seed
        end
        for (int i = 0; i < N_INDEP; i++) begin
            take_bits(5, v);
            pick_reg(5'd0, 5'd0, 1'b1, rd);
            pick_reg(last_rd[0], last_rd[1], 1'b0, rs1);
            pick_reg(last_rd[0], last_rd[1], 1'b0, rs2);
            make_op((i < 19) ? i : int'(v[4:0] % 19), rd, rs1, rs2, insn);  // All 19 ops first
            add_insn(insn, T_INDEP);
        end
        for (int i = 0; i < N_DEP; i++) begin
            take_bits(7, v);
            pick_reg(5'd0, 5'd0, 1'b1, rd);
            make_op(int'(v[6:2] % 19), rd, last_rd[v[0]], last_rd[v[1]], insn);
            add_insn(insn, T_DEP);
        end
        // Unknown opcodes carry a nonzero rd
        for (int i = 0; i < 4; i++) begin
            take_bits(20, v);
            pick_reg(5'd0, 5'd0, 1'b1, rd);
            case (i)
                0:       opc = OPC_LOAD;
                1:       opc = OPC_STORE;
                2:       opc = OPC_BRANCH;
                default: opc = 7'b1111111;
            endcase
            add_insn({v[19:0], rd, opc}, T_X0);
        end
        for (int i = 0; i < 4; i++) begin
            take_bits(5, v);
            pick_reg(5'd0, 5'd0, 1'b1, rs1);
            pick_reg(5'd0, 5'd0, 1'b1, rs2);
            make_op(int'(v[4:0] % 19), 5'd0, rs1, rs2, insn);   // Write to x0
            add_insn(insn, T_X0);
        end
        // R group with x0 on one port and a live register on the other
        for (int i = 0; i < 4; i++) begin
            take_bits(5, v);
            pick_reg(5'd0, 5'd0, 1'b1, rd);
            pick_reg(5'd0, 5'd0, 1'b1, rs2);
            if (i % 2 == 0) begin
                make_op(9 + int'(v[4:0] % 10), rd, 5'd0, rs2, insn);
            end else begin
                make_op(9 + int'(v[4:0] % 10), rd, rs2, 5'd0, insn);
            end
            add_insn(insn, T_X0);
        end
        prog_built = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////

    task automatic check_val(input int t, input string what,
                             input logic [31:0] actual, input logic [31:0] expected);
        checks_run++;
        if (actual !== expected) begin
            errors[t]++;
            $display("[FAIL] %0t: %s: %s got %h, expected %h",
                     $time, test_names[t], what, actual, expected);
        end
    endtask

    task automatic report_test(input int t);
        $display("test %s done, %0d error(s)", test_names[t], errors[t]);
    endtask

    // Commit outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n && commit.en) begin
            commits_seen++;
            if (exp_q.size() == 0) begin
                check_val(T_FETCH, "commit count", commits_seen, total_expected);
            end else begin
                head = exp_q.pop_front();
                check_val(head.test, "commit rd", commit.rd, head.rd);
                check_val(head.test, "commit data", commit.data, head.data);
                pending[head.test]--;
                if (pending[head.test] == 0) begin
                    report_test(head.test);     // Last write of that test
                end
            end
        end
    end

    // Fetch only holds or steps by one word
    always @(negedge clk) begin
        if (rst_n && (imem_addr !== prev_addr)) begin
            check_val(T_FETCH, "fetch address", imem_addr, prev_addr + `RV_PC_STEP);
            prev_addr = imem_addr;
        end
    end

    initial begin
        wait (prog_built);
        repeat (RST_CYCLES + prog_len * 3 + 50) @(posedge clk);
        $display("Timeout: %0d of %0d register writes never committed",
                 exp_q.size(), total_expected);
        $display("Test failed");
        $finish;
    end

    initial begin
        int          total_errors;
        logic [31:0] drain_addr;
        total_errors = 0;
        rst_n <= 1'b0;
        build_program();
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(negedge clk);
            check_val(T_RESET, "commit.en in reset", commit.en, 1'b0);
            check_val(T_RESET, "imem_addr in reset", imem_addr, `RV_RESET_PC);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val(T_RESET, "commit.en after reset", commit.en, 1'b0);
        check_val(T_RESET, "imem_addr after reset", imem_addr, `RV_RESET_PC);
        report_test(T_RESET);

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // Only no-ops remain in flight, so fetch steps every cycle
        drain_addr = imem_addr;
        repeat (DRAIN) @(negedge clk);
        check_val(T_FETCH, "commit count", commits_seen, total_expected);
        check_val(T_FETCH, "fetch steps while idle", imem_addr,
                  drain_addr + DRAIN * `RV_PC_STEP);
        report_test(T_FETCH);

        foreach (errors[i]) total_errors += errors[i];
        $display("summary: %0d checks, %0d errors, %0d of %0d writes committed",
                 checks_run, total_errors, commits_seen, total_expected);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_core
    import rv_pipe_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_insn,
    output rv_commit_t          commit
);

    logic                  stall;      // Hazard interlock level
    rv_if_id_t             if_id;
    logic [`RV_REG_AW-1:0] rs1_idx;
    logic [`RV_REG_AW-1:0] rs2_idx;
    rv_id_ex_t             id_ex;
    rv_ex_wb_t             ex_mem;
    logic                  rf_we;      // Write-back into decode
    logic [`RV_REG_AW-1:0] rf_waddr;
    logic [`RV_XLEN-1:0]   rf_wdata;

    rv_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .imem_insn(imem_insn), .imem_addr(imem_addr),
        .if_id(if_id), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx)
    );

    rv_hazard u_hazard (
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .id_ex(id_ex), .ex_mem(ex_mem), .stall(stall)
    );

    rv_decode u_decode (
        .clk(clk), .rst_n(rst_n), .stall(stall), .if_id(if_id),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata), .id_ex(id_ex)
    );

    rv_execute u_execute (.clk(clk), .rst_n(rst_n), .id_ex(id_ex), .ex_mem(ex_mem));

    rv_writeback u_writeback (
        .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata), .commit(commit)
    );

endmodule

`default_nettype wire

// ==== design/rv_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_writeback
    import rv_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_ex_wb_t             ex_mem,
    output logic                  we,
    output logic [`RV_REG_AW-1:0] waddr,
    output logic [`RV_XLEN-1:0]   wdata,
    output rv_commit_t            commit
);

    rv_ex_wb_t mem_wb;

    ////////////////////////////////////////////////////////////
    // MEM/WB
    ////////////////////////////////////////////////////////////

    // Memory stage kept as a plain delay
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= ex_mem;
        end
    end

    // Register file write, x0 writes dropped here
    assign we    = mem_wb.reg_write && (mem_wb.rd != '0);
    assign waddr = mem_wb.rd;
    assign wdata = mem_wb.result;

    // Commit mirrors the write port
    assign commit.en   = we;
    assign commit.rd   = waddr;
    assign commit.data = wdata;

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_execute
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  rv_id_ex_t id_ex,
    output rv_ex_wb_t ex_mem
);

    rv_funct3_e           f3;
    logic                 alt;          // insn[30]
    rv_alu_op_e           alu_op;
    logic [`RV_XLEN-1:0]  op_a;
    logic [`RV_XLEN-1:0]  op_b;
    logic [`RV_SHAMT_W-1:0] shamt;
    logic [`RV_XLEN-1:0]  alu_res;

    assign f3  = rv_funct3_e'(id_ex.funct_sel[2:0]);
    assign alt = id_ex.funct_sel[3];

    ////////////////////////////////////////////////////////////
    // ALU control
    ////////////////////////////////////////////////////////////

    always_comb begin
        alu_op = ALU_ADD;
        case (id_ex.alu_class)
            CLS_IMM: begin
                case (f3)
                    F3_ADD_SUB: alu_op = ALU_ADD;       // No SUBI
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: alu_op = alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    alu_op = ALU_ADD;
                endcase
            end
            CLS_REG: begin
                case ({alt, f3})
                    {1'b0, F3_ADD_SUB}: alu_op = ALU_ADD;
                    {1'b1, F3_ADD_SUB}: alu_op = ALU_SUB;
                    {1'b0, F3_SLL}:     alu_op = ALU_SLL;
                    {1'b0, F3_SLT}:     alu_op = ALU_SLT;
                    {1'b0, F3_SLTU}:    alu_op = ALU_SLTU;
                    {1'b0, F3_XOR}:     alu_op = ALU_XOR;
                    {1'b0, F3_SRL_SRA}: alu_op = ALU_SRL;
                    {1'b1, F3_SRL_SRA}: alu_op = ALU_SRA;
                    {1'b0, F3_OR}:      alu_op = ALU_OR;
                    {1'b0, F3_AND}:     alu_op = ALU_AND;
                    default:            alu_op = ALU_ADD;   // Bad funct7 falls back to ADD
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Operands and ALU
    ////////////////////////////////////////////////////////////

    assign op_a  = id_ex.rs1_val;
    assign op_b  = id_ex.alu_src_imm ? id_ex.imm : id_ex.rs2_val;
    assign shamt = op_b[`RV_SHAMT_W-1:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};   // Plain unsigned compare
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = '0;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= '{reg_write: id_ex.reg_write, rd: id_ex.rd, result: alu_res};
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  rv_if_id_t             if_id,
    input  logic                  we,       // From write-back
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata,
    output rv_id_ex_t             id_ex
);

    // Nothing writes, nothing reaches commit
    localparam rv_id_ex_t ID_EX_BUBBLE = '{
        reg_write:   1'b0,
        alu_class:   CLS_IMM,
        alu_src_imm: 1'b0,
        pc:          '0,
        rs1_val:     '0,
        rs2_val:     '0,
        imm:         '0,
        funct_sel:   '0,
        rd:          '0
    };

    rv_insn_r_t          insn_r;
    rv_insn_i_t          insn_i;
    rv_opcode_e          opcode;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    rv_id_ex_t           id_ex_d;

    assign insn_r = if_id.insn;
    assign insn_i = if_id.insn;
    assign opcode = rv_opcode_e'(insn_r.opcode);

    rv_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (insn_r.rs1),
        .raddr2 (insn_r.rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    ////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        id_ex_d = ID_EX_BUBBLE;
        case (opcode)
            OPC_OP_IMM: begin
                id_ex_d.reg_write   = 1'b1;
                id_ex_d.alu_class   = CLS_IMM;
                id_ex_d.alu_src_imm = 1'b1;     // b = imm
            end
            OPC_OP: begin
                id_ex_d.reg_write   = 1'b1;
                id_ex_d.alu_class   = CLS_REG;
                id_ex_d.alu_src_imm = 1'b0;     // b = rs2
            end
            default: ;                          // Loads, stores, branches etc. as no-ops
        endcase
        id_ex_d.pc        = if_id.pc;
        id_ex_d.rs1_val   = rs1_val;
        id_ex_d.rs2_val   = rs2_val;
        id_ex_d.imm       = {{(`RV_XLEN-12){insn_i.imm[11]}}, insn_i.imm};
        id_ex_d.funct_sel = {insn_r.funct7[5], insn_r.funct3};
        id_ex_d.rd        = id_ex_d.reg_write ? insn_r.rd : '0;
    end

    // ID/EX, bubble while interlocked
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= ID_EX_BUBBLE;
        end else if (stall) begin
            id_ex <= ID_EX_BUBBLE;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_REG_AW-1:0] raddr1,
    input  logic [`RV_REG_AW-1:0] raddr2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2,
    input  logic                  we,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    // Rising-edge write, x0 never stored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;   // Architectural state starts at zero
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Read port with same-cycle write bypass
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we && (waddr == addr)) begin
            return wdata;                        // Write in flight wins
        end
        return regs[addr];
    endfunction

    always_comb rdata1 = read_port(raddr1);
    always_comb rdata2 = read_port(raddr2);

endmodule

`default_nettype wire

// ==== design/rv_hazard.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_hazard
    import rv_pipe_pkg::*;
(
    input  logic [`RV_REG_AW-1:0] rs1_idx,
    input  logic [`RV_REG_AW-1:0] rs2_idx,
    input  rv_id_ex_t             id_ex,
    input  rv_ex_wb_t             ex_mem,
    output logic                  stall
);

    // Younger stage writes a register decode wants to read
    function automatic logic raw_hit(input logic                  wr,
                                     input logic [`RV_REG_AW-1:0] rd,
                                     input logic [`RV_REG_AW-1:0] ra,
                                     input logic [`RV_REG_AW-1:0] rb);
        return wr && (rd != '0) && ((rd == ra) || (rd == rb));   // x0 never hazards
    endfunction

    // MEM/WB not checked, regfile forwards that write
    assign stall = raw_hit(id_ex.reg_write, id_ex.rd, rs1_idx, rs2_idx)
                 | raw_hit(ex_mem.reg_write, ex_mem.rd, rs1_idx, rs2_idx);

endmodule

`default_nettype wire

// ==== design/rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_fetch
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic [`RV_XLEN-1:0]   imem_insn,
    output logic [`RV_XLEN-1:0]   imem_addr,
    output rv_if_id_t             if_id,
    output logic [`RV_REG_AW-1:0] rs1_idx,
    output logic [`RV_REG_AW-1:0] rs2_idx
);

    logic [`RV_XLEN-1:0] pc;
    rv_insn_r_t          held;     // Instruction now in decode

    assign imem_addr = pc;         // Memory answers in the same cycle

    // PC holds on stall, otherwise next word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else if (!stall) begin
            pc <= pc + `RV_PC_STEP;
        end
    end

    // IF/ID, all-zero word decodes as a no-op
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (!stall) begin
            if_id <= '{pc: pc, insn: imem_insn};
        end
    end

    // Source fields for the interlock
    assign held    = if_id.insn;
    assign rs1_idx = held.rs1;
    assign rs2_idx = held.rs2;   // Imm bits on I-type, may stall spuriously

endmodule

`default_nettype wire

// ==== design/rv_pipe_pkg.sv ====
`default_nettype none

`include "rv_core_consts.svh"

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    ////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////

    // IF/ID
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] insn;      // Raw instruction word
    } rv_if_id_t;

    // ID/EX, reg_write 0 and rd 0 make a bubble
    typedef struct packed {
        logic                  reg_write;
        rv_alu_class_e         alu_class;
        logic                  alu_src_imm;    // Operand b from imm
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   rs1_val;
        logic [`RV_XLEN-1:0]   rs2_val;
        logic [`RV_XLEN-1:0]   imm;            // Sign-extended I immediate
        logic [3:0]            funct_sel;      // {insn[30], funct3}
        logic [`RV_REG_AW-1:0] rd;
    } rv_id_ex_t;

    // EX/MEM and MEM/WB share this layout
    typedef struct packed {
        logic                  reg_write;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   result;
    } rv_ex_wb_t;

    ////////////////////////////////////////////////////////////
    // Commit port
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  en;     // One retired write to a nonzero rd
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } rv_commit_t;

endpackage

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // Major opcodes in insn[6:0]
    // Only OP_IMM and OP execute here and the rest decode as no-ops
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    // ALU operation codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_SLL  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_XOR  = 4'b0110,
        ALU_OR   = 4'b0111,
        ALU_AND  = 4'b1000,
        ALU_SRA  = 4'b1001
    } rv_alu_op_e;

    // ALUOp field carried from decode to ALU control
    typedef enum logic [1:0] {
        CLS_IMM = 2'b00,    // Register-immediate group
        CLS_REG = 2'b10     // Register-register group
    } rv_alu_class_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } rv_funct3_e;

    // R-type field layout
    typedef struct packed {
        logic [6:0] funct7;     // Bit 5 is insn[30] and selects SUB or SRA
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_insn_r_t;

    // I-type field layout
    typedef struct packed {
        logic [11:0] imm;       // Sign bit at insn[31]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_insn_i_t;

endpackage

`default_nettype wire

// ==== design/rv_core_consts.svh ====
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

`define RV_XLEN      32              // Data and address width
`define RV_REG_AW    5               // Register index width
`define RV_NUM_REGS  32              // x0..x31
`define RV_SHAMT_W   5               // Low bits of operand b used by shifts

////////////////////////////////////////////////////////////
// Fetch constants
////////////////////////////////////////////////////////////

// One 32-bit instruction per word
`define RV_PC_STEP   32'd4
`define RV_RESET_PC  32'h0000_0000   // First fetch address

`endif
